// ==== hdl/tomasulo_macros.svh ====
`ifndef TOMASULO_MACROS_SVH
`define TOMASULO_MACROS_SVH

// Widths of the architectural and rename state.
`define REG_ADDR_W 5
`define NUM_REGS 32
`define TAG_W 6
`define NUM_TAGS 64
`define DATA_W 32
`define IMM_W 16
`define OPCODE_W 6

// Major opcodes of the supported MIPS subset.
`define OPCODE_RTYPE 6'h00
`define OPCODE_J 6'h02
`define OPCODE_BEQ 6'h04
`define OPCODE_BNE 6'h05
`define OPCODE_LW 6'h23
`define OPCODE_SW 6'h2b

// R-type function codes that leave the integer queue.
`define FUNCT_MULT 6'h18
`define FUNCT_MULTU 6'h19
`define FUNCT_DIV 6'h1a
`define FUNCT_DIVU 6'h1b

// Opcodes seen by the load/store queue.
`define LS_FUNC_LW 1'b0
`define LS_FUNC_SW 1'b1

`endif

// ==== hdl/tomasulo_pkg.sv ====
`include "tomasulo_macros.svh"

package tomasulo_pkg;

   typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
   typedef logic [`TAG_W-1:0] tag_t;
   typedef logic [`DATA_W-1:0] word_t;

   // One broadcast on the common data bus.
   // The branch fields report the outcome of a resolved BEQ or BNE.
   typedef struct packed {
      tag_t  tag;
      logic  valid;
      word_t data;
      logic  branch;
      logic  branch_taken;
   } cdb_t;

   // Payload shared by all four execution queues.
   // A source with its valid bit low waits on the CDB for the given tag.
   typedef struct packed {
      logic [`IMM_W-1:0] imm;
      tag_t              rdtag;
      tag_t              rstag;
      tag_t              rttag;
      word_t             rsdata;
      word_t             rtdata;
      logic              rsvalid;
      logic              rtvalid;
   } dispatch_bus_t;

   // Dispatch runs freely or waits for a branch outcome.
   typedef enum logic {
      DISPATCH,
      BRANCH_STALL
   } dispatch_state_t;

endpackage

// ==== hdl/tag_fifo.sv ====
`timescale 1ns/1ps

`include "tomasulo_macros.svh"

module tag_fifo
   import tomasulo_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic pop,
   input  cdb_t cdb,
   output tag_t head,
   output logic empty,
   output logic full
);

   localparam int PTR_W = $clog2(`NUM_TAGS);
   localparam int CNT_W = $clog2(`NUM_TAGS + 1);

   tag_t             mem [`NUM_TAGS];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [CNT_W-1:0] count;
   logic             push;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      next_ptr = (ptr == PTR_W'(`NUM_TAGS - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // Every tag retired on the CDB becomes free again.
   assign push  = cdb.valid;
   assign head  = mem[rd_ptr];
   assign empty = (count == '0);
   assign full  = (count == CNT_W'(`NUM_TAGS));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         // All tags start out free, handed out in ascending order.
         for (int i = 0; i < `NUM_TAGS; i++) begin
            mem[i] <= tag_t'(i);
         end
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= CNT_W'(`NUM_TAGS);
      end else begin
         if (push) begin
            mem[wr_ptr] <= cdb.tag;
            wr_ptr      <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   // Only tags handed out by dispatch can come back, so the count stays in range.
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);

endmodule

// ==== hdl/reg_status_table.sv ====
`timescale 1ns/1ps

`include "tomasulo_macros.svh"

module reg_status_table
   import tomasulo_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  reg_addr_t            rs_addr,
   input  reg_addr_t            rt_addr,
   input  logic                 rename_en,
   input  reg_addr_t            rename_addr,
   input  tag_t                 rename_tag,
   input  cdb_t                 cdb,
   output logic                 rs_busy,
   output logic                 rt_busy,
   output tag_t                 rs_tag,
   output tag_t                 rt_tag,
   output logic [`NUM_REGS-1:0] wr_onehot
);

   logic [`NUM_REGS-1:0] busy;
   tag_t                 tag [`NUM_REGS];
   logic [`NUM_REGS-1:0] rename_hit;

   assign rs_busy = busy[rs_addr];
   assign rt_busy = busy[rt_addr];
   assign rs_tag  = tag[rs_addr];
   assign rt_tag  = tag[rt_addr];

   // A register picks up the CDB value only while it still waits on that tag.
   // A rename in the same cycle makes the broadcast value stale for it.
   always_comb begin
      for (int i = 0; i < `NUM_REGS; i++) begin
         rename_hit[i] = rename_en && (rename_addr == reg_addr_t'(i));
         wr_onehot[i]  = cdb.valid && busy[i] && (tag[i] == cdb.tag) && !rename_hit[i];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy <= '0;
      end else begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            if (rename_hit[i]) begin
               busy[i] <= 1'b1;
            end else if (wr_onehot[i]) begin
               busy[i] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rename_en) begin
         tag[rename_addr] <= rename_tag;
      end
   end

   // Tags in flight are unique, so a broadcast can complete at most one register.
   a_onehot_write: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(wr_onehot));

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps

`include "tomasulo_macros.svh"

module regfile
   import tomasulo_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [`NUM_REGS-1:0] wr_onehot,
   input  word_t                wdata,
   input  reg_addr_t            rs_addr,
   input  reg_addr_t            rt_addr,
   output word_t                rs_data,
   output word_t                rt_data,
   input  reg_addr_t            debug_addr,
   output word_t                debug_data
);

   word_t regs [`NUM_REGS];

   // Reads are combinational. Dispatch handles same-cycle CDB forwarding itself.
   assign rs_data    = regs[rs_addr];
   assign rt_data    = regs[rt_addr];
   assign debug_data = regs[debug_addr];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         // The status table selects the one register still waiting on this tag.
         for (int i = 0; i < `NUM_REGS; i++) begin
            if (wr_onehot[i]) begin
               regs[i] <= wdata;
            end
         end
      end
   end

endmodule

// ==== hdl/dispatch_ctrl.sv ====
`timescale 1ns/1ps

`include "tomasulo_macros.svh"

module dispatch_ctrl
   import tomasulo_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  word_t                ifq_inst,
   input  word_t                ifq_pc_plus4,
   input  logic                 ifq_empty,
   output logic                 ifq_ren,
   output logic                 ifq_branch_valid,
   output word_t                ifq_branch_addr,
   input  cdb_t                 cdb,
   output logic                 eq_int_en,
   output logic                 eq_ls_en,
   output logic                 eq_mult_en,
   output logic                 eq_div_en,
   input  logic                 eq_int_ready,
   input  logic                 eq_ls_ready,
   input  logic                 eq_mult_ready,
   input  logic                 eq_div_ready,
   output logic [`OPCODE_W-1:0] eq_int_opcode,
   output logic                 eq_ls_opcode,
   output dispatch_bus_t        eq_bus,
   output reg_addr_t            rs_addr,
   output reg_addr_t            rt_addr,
   input  logic                 rs_busy,
   input  logic                 rt_busy,
   input  tag_t                 rs_tag,
   input  tag_t                 rt_tag,
   input  word_t                rs_data,
   input  word_t                rt_data,
   output logic                 rename_en,
   output reg_addr_t            rename_addr,
   output tag_t                 rename_tag,
   output logic                 tag_pop,
   input  tag_t                 tag_head,
   input  logic                 tag_empty
);

   // Queue indices into the ready and enable vectors.
   localparam logic [1:0] Q_INT  = 2'd0;
   localparam logic [1:0] Q_LS   = 2'd1;
   localparam logic [1:0] Q_MULT = 2'd2;
   localparam logic [1:0] Q_DIV  = 2'd3;

   dispatch_state_t     state;
   dispatch_state_t     state_next;
   logic [`OPCODE_W-1:0] opcode;
   logic [`OPCODE_W-1:0] funct;
   reg_addr_t           rd_addr;
   logic [`IMM_W-1:0]   imm;
   logic [25:0]         jump_index;
   word_t               branch_target;
   word_t               branch_target_r;
   word_t               jump_target;
   logic [1:0]          q_sel;
   logic [3:0]          q_ready;
   logic [3:0]          q_en;
   logic                needs_queue;
   logic                needs_tag;
   logic                is_branch;
   logic                is_jump;
   logic                is_load;
   logic                is_store;
   logic                rs_fwd;
   logic                rt_fwd;
   logic                can_issue;
   logic                go;

   assign opcode     = ifq_inst[31:26];
   assign rs_addr    = ifq_inst[25:21];
   assign rt_addr    = ifq_inst[20:16];
   assign rd_addr    = ifq_inst[15:11];
   assign funct      = ifq_inst[5:0];
   assign imm        = ifq_inst[15:0];
   assign jump_index = ifq_inst[25:0];

   assign branch_target = ifq_pc_plus4 + {{(`DATA_W - `IMM_W - 2){imm[`IMM_W-1]}}, imm, 2'b00};
   assign jump_target   = {ifq_pc_plus4[31:28], jump_index, 2'b00};

   always_comb begin
      q_sel         = Q_INT;
      needs_queue   = 1'b0;
      needs_tag     = 1'b0;
      is_branch     = 1'b0;
      is_jump       = 1'b0;
      is_load       = 1'b0;
      is_store      = 1'b0;
      eq_int_opcode = '0;
      eq_ls_opcode  = `LS_FUNC_LW;
      case (opcode)
         `OPCODE_RTYPE: begin
            needs_queue = 1'b1;
            needs_tag   = 1'b1;
            case (funct)
               `FUNCT_MULT, `FUNCT_MULTU: q_sel = Q_MULT;
               `FUNCT_DIV, `FUNCT_DIVU: q_sel = Q_DIV;
               default: eq_int_opcode = funct;
            endcase
         end
         `OPCODE_BEQ, `OPCODE_BNE: begin
            // The integer unit compares the operands and reports on the CDB.
            needs_queue   = 1'b1;
            is_branch     = 1'b1;
            eq_int_opcode = opcode;
         end
         `OPCODE_J: begin
            is_jump = 1'b1;
         end
         `OPCODE_LW: begin
            q_sel        = Q_LS;
            needs_queue  = 1'b1;
            needs_tag    = 1'b1;
            is_load      = 1'b1;
            eq_ls_opcode = `LS_FUNC_LW;
         end
         `OPCODE_SW: begin
            q_sel        = Q_LS;
            needs_queue  = 1'b1;
            is_store     = 1'b1;
            eq_ls_opcode = `LS_FUNC_SW;
         end
         default: begin
            // Unsupported opcodes never leave the fetch queue.
         end
      endcase
   end

   // A source still busy is resolved if its producer broadcasts this very cycle.
   assign rs_fwd = rs_busy && cdb.valid && (cdb.tag == rs_tag);
   assign rt_fwd = rt_busy && cdb.valid && (cdb.tag == rt_tag);

   always_comb begin
      eq_bus.imm     = imm;
      eq_bus.rdtag   = tag_head;
      eq_bus.rstag   = rs_tag;
      eq_bus.rttag   = is_load ? tag_head : rt_tag;
      eq_bus.rsdata  = rs_fwd ? cdb.data : rs_data;
      eq_bus.rtdata  = rt_fwd ? cdb.data : rt_data;
      eq_bus.rsvalid = !rs_busy || rs_fwd;
      eq_bus.rtvalid = is_store || !rt_busy || rt_fwd;
   end

   assign q_ready   = {eq_div_ready, eq_mult_ready, eq_ls_ready, eq_int_ready};
   assign can_issue = !ifq_empty && needs_queue && q_ready[q_sel] && !(needs_tag && tag_empty);

   always_comb begin
      go               = 1'b0;
      state_next       = state;
      ifq_branch_valid = 1'b0;
      ifq_branch_addr  = jump_target;
      case (state)
         DISPATCH: begin
            go               = can_issue;
            ifq_branch_valid = is_jump && !ifq_empty;
            if (go && is_branch) begin
               state_next = BRANCH_STALL;
            end
         end
         BRANCH_STALL: begin
            // The instruction after the branch only issues on a not-taken outcome.
            go               = can_issue && cdb.branch && !cdb.branch_taken;
            ifq_branch_valid = cdb.branch && cdb.branch_taken;
            ifq_branch_addr  = branch_target_r;
            if (cdb.branch) begin
               state_next = (go && is_branch) ? BRANCH_STALL : DISPATCH;
            end
         end
         default: state_next = DISPATCH;
      endcase
   end

   assign q_en       = go ? (4'b0001 << q_sel) : 4'b0000;
   assign eq_int_en  = q_en[Q_INT];
   assign eq_ls_en   = q_en[Q_LS];
   assign eq_mult_en = q_en[Q_MULT];
   assign eq_div_en  = q_en[Q_DIV];
   assign ifq_ren    = go;

   // Loads write rt, all other tagged instructions write rd.
   assign tag_pop     = go && needs_tag;
   assign rename_en   = tag_pop;
   assign rename_addr = is_load ? rt_addr : rd_addr;
   assign rename_tag  = tag_head;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= DISPATCH;
      end else begin
         state <= state_next;
      end
   end

   always_ff @(posedge clk) begin
      if (go && is_branch) begin
         branch_target_r <= branch_target;
      end
   end

   // A branch outcome only arrives while a dispatched branch waits for it.
   a_outcome_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
      cdb.branch |-> state == BRANCH_STALL);
   // Fetch keeps an instruction in place until dispatch pops it or redirects fetch.
   a_inst_held: assert property (@(posedge clk) disable iff (!rst_n)
      !ifq_empty && !ifq_ren && !ifq_branch_valid |=> ifq_empty || $stable(ifq_inst));

endmodule

// ==== hdl/dispatch_top.sv ====
`timescale 1ns/1ps

`include "tomasulo_macros.svh"

module dispatch_top
   import tomasulo_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  word_t                ifq_inst,
   input  word_t                ifq_pc_plus4,
   input  logic                 ifq_empty,
   output logic                 ifq_ren,
   output logic                 ifq_branch_valid,
   output word_t                ifq_branch_addr,
   input  cdb_t                 cdb,
   output logic                 eq_int_en,
   output logic                 eq_ls_en,
   output logic                 eq_mult_en,
   output logic                 eq_div_en,
   input  logic                 eq_int_ready,
   input  logic                 eq_ls_ready,
   input  logic                 eq_mult_ready,
   input  logic                 eq_div_ready,
   output logic [`OPCODE_W-1:0] eq_int_opcode,
   output logic                 eq_ls_opcode,
   output dispatch_bus_t        eq_bus,
   input  reg_addr_t            debug_addr,
   output word_t                debug_data
);

   reg_addr_t            rs_addr;
   reg_addr_t            rt_addr;
   logic                 rs_busy;
   logic                 rt_busy;
   tag_t                 rs_tag;
   tag_t                 rt_tag;
   word_t                rs_data;
   word_t                rt_data;
   logic                 rename_en;
   reg_addr_t            rename_addr;
   tag_t                 rename_tag;
   logic                 tag_pop;
   tag_t                 tag_head;
   logic                 tag_empty;
   logic [`NUM_REGS-1:0] wr_onehot;

   dispatch_ctrl i_ctrl (
      .clk, .rst_n, .ifq_inst, .ifq_pc_plus4, .ifq_empty, .ifq_ren,
      .ifq_branch_valid, .ifq_branch_addr, .cdb,
      .eq_int_en, .eq_ls_en, .eq_mult_en, .eq_div_en,
      .eq_int_ready, .eq_ls_ready, .eq_mult_ready, .eq_div_ready,
      .eq_int_opcode, .eq_ls_opcode, .eq_bus,
      .rs_addr, .rt_addr, .rs_busy, .rt_busy, .rs_tag, .rt_tag, .rs_data, .rt_data,
      .rename_en, .rename_addr, .rename_tag, .tag_pop, .tag_head, .tag_empty
   );

   regfile i_regfile (
      .clk, .rst_n, .wr_onehot, .wdata (cdb.data), .rs_addr, .rt_addr,
      .rs_data, .rt_data, .debug_addr, .debug_data
   );

   reg_status_table i_rst (
      .clk, .rst_n, .rs_addr, .rt_addr, .rename_en, .rename_addr, .rename_tag,
      .cdb, .rs_busy, .rt_busy, .rs_tag, .rt_tag, .wr_onehot
   );

   // Only the empty flag matters to dispatch. Full is unused at this level.
   tag_fifo i_tag_fifo (
      .clk, .rst_n, .pop (tag_pop), .cdb, .head (tag_head), .empty (tag_empty), .full ()
   );

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Reset covers 16 rising edges and is released on a falling edge.
   initial begin
      rst_n = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n <= 1'b1;
   end

endmodule

// ==== sim/dispatch_tb.sv ====
`timescale 1ns/1ps

`include "tomasulo_macros.svh"

module dispatch_tb
   import tomasulo_pkg::*;
();

   localparam int TIMEOUT = 200;
   localparam logic [31:0] SEED = 32'h14a1d83e;
   localparam logic [3:0] EN_NONE = 4'b0000;
   localparam logic [3:0] EN_INT  = 4'b0001;
   localparam logic [3:0] EN_LS   = 4'b0010;
   localparam logic [3:0] EN_MULT = 4'b0100;
   localparam logic [3:0] EN_DIV  = 4'b1000;

   // Expected response for the cycle that ends at the next rising edge.
   typedef struct packed {
      logic                 on;
      logic [3:0]           en;
      logic                 bv;
      word_t                baddr;
      logic                 chk_rdtag;
      tag_t                 rdtag;
      logic                 chk_int_op;
      logic [`OPCODE_W-1:0] int_op;
      logic                 chk_ls_op;
      logic                 ls_op;
      logic                 chk_rs;
      logic                 rsvalid;
      tag_t                 rstag;
      word_t                rsdata;
      logic                 chk_rttag;
      tag_t                 rttag;
      logic                 chk_rtvalid;
      logic                 rtvalid;
      logic                 chk_debug;
      word_t                debug;
   } expect_t;

   logic                 clk;
   logic                 rst_n;
   word_t                ifq_inst;
   word_t                ifq_pc_plus4;
   logic                 ifq_empty;
   logic                 ifq_ren;
   logic                 ifq_branch_valid;
   word_t                ifq_branch_addr;
   cdb_t                 cdb;
   logic                 eq_int_en;
   logic                 eq_ls_en;
   logic                 eq_mult_en;
   logic                 eq_div_en;
   logic                 eq_int_ready;
   logic                 eq_ls_ready;
   logic                 eq_mult_ready;
   logic                 eq_div_ready;
   logic [`OPCODE_W-1:0] eq_int_opcode;
   logic                 eq_ls_opcode;
   dispatch_bus_t        eq_bus;
   reg_addr_t            debug_addr;
   word_t                debug_data;
   logic [3:0]           en_vec;
   logic [3:0]           ready_vec;
   expect_t              want;

   // Reference model of the free tags and of each architectural register.
   tag_t  free_tags [$];
   logic  busy_m [`NUM_REGS];
   tag_t  tag_m [`NUM_REGS];
   word_t val_m [`NUM_REGS];

   assign en_vec    = {eq_div_en, eq_mult_en, eq_ls_en, eq_int_en};
   assign ready_vec = {eq_div_ready, eq_mult_ready, eq_ls_ready, eq_int_ready};

   tb_clock i_clock (.clk, .rst_n);

   dispatch_top i_dut (
      .clk, .rst_n, .ifq_inst, .ifq_pc_plus4, .ifq_empty, .ifq_ren,
      .ifq_branch_valid, .ifq_branch_addr, .cdb,
      .eq_int_en, .eq_ls_en, .eq_mult_en, .eq_div_en,
      .eq_int_ready, .eq_ls_ready, .eq_mult_ready, .eq_div_ready,
      .eq_int_opcode, .eq_ls_opcode, .eq_bus, .debug_addr, .debug_data
   );

   task automatic stop_with(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   a_idle: assert property (@(posedge clk) disable iff (!rst_n)
      ifq_empty |-> (en_vec == EN_NONE) && !ifq_ren && !ifq_branch_valid)
      else stop_with("Dispatch activity while the fetch queue was empty");
   a_en_ready: assert property (@(posedge clk) disable iff (!rst_n)
      (en_vec & ~ready_vec) == EN_NONE)
      else stop_with("A queue enable was high while that queue was not ready");
   a_enables: assert property (@(posedge clk) disable iff (!rst_n)
      want.on |-> {en_vec, ifq_ren} == {want.en, |want.en})
      else stop_with($sformatf("FAIL {enables, ifq_ren} got 0x%0h expected 0x%0h",
         $sampled({en_vec, ifq_ren}), $sampled({want.en, |want.en})));
   a_bvalid: assert property (@(posedge clk) disable iff (!rst_n)
      want.on |-> ifq_branch_valid == want.bv)
      else stop_with($sformatf("FAIL ifq_branch_valid got 0x%0h expected 0x%0h",
         $sampled(ifq_branch_valid), $sampled(want.bv)));
   a_baddr: assert property (@(posedge clk) disable iff (!rst_n)
      want.on && want.bv |-> ifq_branch_addr == want.baddr)
      else stop_with($sformatf("FAIL ifq_branch_addr got 0x%0h expected 0x%0h",
         $sampled(ifq_branch_addr), $sampled(want.baddr)));
   a_rdtag: assert property (@(posedge clk) disable iff (!rst_n)
      want.chk_rdtag |-> eq_bus.rdtag == want.rdtag)
      else stop_with($sformatf("FAIL eq_bus.rdtag got 0x%0h expected 0x%0h",
         $sampled(eq_bus.rdtag), $sampled(want.rdtag)));
   a_int_op: assert property (@(posedge clk) disable iff (!rst_n)
      want.chk_int_op |-> eq_int_opcode == want.int_op)
      else stop_with($sformatf("FAIL eq_int_opcode got 0x%0h expected 0x%0h",
         $sampled(eq_int_opcode), $sampled(want.int_op)));
   a_ls_op: assert property (@(posedge clk) disable iff (!rst_n)
      want.chk_ls_op |-> eq_ls_opcode == want.ls_op)
      else stop_with($sformatf("FAIL eq_ls_opcode got 0x%0h expected 0x%0h",
         $sampled(eq_ls_opcode), $sampled(want.ls_op)));
   a_rsvalid: assert property (@(posedge clk) disable iff (!rst_n)
      want.chk_rs |-> eq_bus.rsvalid == want.rsvalid)
      else stop_with($sformatf("FAIL eq_bus.rsvalid got 0x%0h expected 0x%0h",
         $sampled(eq_bus.rsvalid), $sampled(want.rsvalid)));
   a_rstag: assert property (@(posedge clk) disable iff (!rst_n)
      want.chk_rs && !want.rsvalid |-> eq_bus.rstag == want.rstag)
      else stop_with($sformatf("FAIL eq_bus.rstag got 0x%0h expected 0x%0h",
         $sampled(eq_bus.rstag), $sampled(want.rstag)));
   a_rsdata: assert property (@(posedge clk) disable iff (!rst_n)
      want.chk_rs && want.rsvalid |-> eq_bus.rsdata == want.rsdata)
      else stop_with($sformatf("FAIL eq_bus.rsdata got 0x%0h expected 0x%0h",
         $sampled(eq_bus.rsdata), $sampled(want.rsdata)));
   a_rttag: assert property (@(posedge clk) disable iff (!rst_n)
      want.chk_rttag |-> eq_bus.rttag == want.rttag)
      else stop_with($sformatf("FAIL eq_bus.rttag got 0x%0h expected 0x%0h",
         $sampled(eq_bus.rttag), $sampled(want.rttag)));
   a_rtvalid: assert property (@(posedge clk) disable iff (!rst_n)
      want.chk_rtvalid |-> eq_bus.rtvalid == want.rtvalid)
      else stop_with($sformatf("FAIL eq_bus.rtvalid got 0x%0h expected 0x%0h",
         $sampled(eq_bus.rtvalid), $sampled(want.rtvalid)));
   a_debug: assert property (@(posedge clk) disable iff (!rst_n)
      want.chk_debug |-> debug_data == want.debug)
      else stop_with($sformatf("FAIL debug_data got 0x%0h expected 0x%0h",
         $sampled(debug_data), $sampled(want.debug)));

   function automatic word_t rtype(input reg_addr_t rs, input reg_addr_t rt,
                                   input reg_addr_t rd, input logic [5:0] funct);
      rtype = {`OPCODE_RTYPE, rs, rt, rd, 5'd0, funct};
   endfunction

   function automatic word_t itype(input logic [5:0] op, input reg_addr_t rs,
                                   input reg_addr_t rt, input logic [15:0] imm);
      itype = {op, rs, rt, imm};
   endfunction

   // Branch target is pc+4 plus the sign-extended word offset.
   function automatic word_t branch_dest(input word_t pc4, input logic [15:0] imm);
      branch_dest = pc4 + 32'($signed(imm)) * 4;
   endfunction

   task automatic present(input word_t inst, input word_t pc4);
      ifq_inst     = inst;
      ifq_pc_plus4 = pc4;
      ifq_empty    = 1'b0;
   endtask

   task automatic expect_issue(input logic [3:0] en);
      want.on        = 1'b1;
      want.en        = en;
      want.chk_rdtag = 1'b1;
      want.rdtag     = free_tags[0];
   endtask

   // A busy source is ready only if its producer is on the CDB in this cycle.
   task automatic expect_rs(input reg_addr_t rs);
      want.chk_rs = 1'b1;
      if (busy_m[rs] && !(cdb.valid && cdb.tag == tag_m[rs])) begin
         want.rsvalid = 1'b0;
         want.rstag   = tag_m[rs];
      end else begin
         want.rsvalid = 1'b1;
         want.rsdata  = busy_m[rs] ? cdb.data : val_m[rs];
      end
   endtask

   task automatic complete_tag(input tag_t t, input word_t d);
      for (int r = 0; r < `NUM_REGS; r++) begin
         if (busy_m[r] && tag_m[r] == t) begin
            busy_m[r] = 1'b0;
            val_m[r]  = d;
         end
      end
      free_tags.push_back(t);
   endtask

   // Runs one clock and updates the model. The CDB goes first, so a rename wins.
   task automatic finish_cycle(input logic renamed, input reg_addr_t dest);
      cdb_t seen;
      tag_t t;
      seen = cdb;
      @(posedge clk);
      @(negedge clk);
      if (seen.valid) begin
         complete_tag(seen.tag, seen.data);
      end
      if (renamed) begin
         t            = free_tags.pop_front();
         busy_m[dest] = 1'b1;
         tag_m[dest]  = t;
      end
      cdb  = '0;
      want = '0;
   endtask

   task automatic check_register(input reg_addr_t addr);
      ifq_empty      = 1'b1;
      debug_addr     = addr;
      want.chk_debug = 1'b1;
      want.debug     = val_m[addr];
      finish_cycle(1'b0, 5'd0);
   endtask

   initial begin
      word_t      inst;
      word_t      jump_to;
      reg_addr_t  dest;
      logic [3:0] queue;
      logic [3:0] rdy;
      logic [5:0] funct;
      logic       dispatched;
      void'($urandom(SEED));
      ifq_inst      = '0;
      ifq_pc_plus4  = '0;
      ifq_empty     = 1'b1;
      cdb           = '0;
      eq_int_ready  = 1'b1;
      eq_ls_ready   = 1'b1;
      eq_mult_ready = 1'b1;
      eq_div_ready  = 1'b1;
      debug_addr    = '0;
      want          = '0;
      for (int i = 0; i < `NUM_TAGS; i++) begin
         free_tags.push_back(tag_t'(i));
      end
      for (int r = 0; r < `NUM_REGS; r++) begin
         busy_m[r] = 1'b0;
         tag_m[r]  = '0;
         val_m[r]  = '0;
      end
      for (int n = 0; n < TIMEOUT && !rst_n; n++) begin
         @(negedge clk);
      end
      if (!rst_n) begin
         stop_with("Reset was never released");
      end

      // Every register reads zero after reset.
      for (int r = 0; r < `NUM_REGS; r++) begin
         check_register(reg_addr_t'(r));
      end

      // Back-to-back ALU instructions take tags in order.
      for (int i = 1; i <= 5; i++) begin
         funct = (i % 2 == 1) ? 6'h20 : 6'h22;
         present(rtype(5'd0, 5'd0, reg_addr_t'(i), funct), word_t'(32'h100 + 4 * i));
         expect_issue(EN_INT);
         want.chk_int_op = 1'b1;
         want.int_op     = funct;
         finish_cycle(1'b1, reg_addr_t'(i));
      end

      // r6 reads r1 while r1 still waits on its producer.
      present(rtype(5'd1, 5'd0, 5'd6, 6'h20), 32'h0000_0120);
      expect_issue(EN_INT);
      expect_rs(5'd1);
      finish_cycle(1'b1, 5'd6);
      ifq_empty = 1'b1;
      cdb.valid = 1'b1;
      cdb.tag   = tag_m[1];
      cdb.data  = 32'h1234_5678;
      finish_cycle(1'b0, 5'd0);
      check_register(5'd1);
      present(rtype(5'd2, 5'd0, 5'd7, 6'h20), 32'h0000_0124);
      cdb.valid = 1'b1;
      cdb.tag   = tag_m[2];
      cdb.data  = 32'hcafe_f00d;
      expect_issue(EN_INT);
      expect_rs(5'd2);
      finish_cycle(1'b1, 5'd7);
      check_register(5'd2);

      present(rtype(5'd3, 5'd4, 5'd8, `FUNCT_MULT), 32'h0000_0130);
      expect_issue(EN_MULT);
      finish_cycle(1'b1, 5'd8);
      present(rtype(5'd3, 5'd4, 5'd9, `FUNCT_DIV), 32'h0000_0134);
      expect_issue(EN_DIV);
      finish_cycle(1'b1, 5'd9);
      present(itype(`OPCODE_LW, 5'd0, 5'd10, 16'h0040), 32'h0000_0138);
      expect_issue(EN_LS);
      want.chk_ls_op = 1'b1;
      want.ls_op     = `LS_FUNC_LW;
      want.chk_rttag = 1'b1;
      want.rttag     = free_tags[0];
      finish_cycle(1'b1, 5'd10);
      present(itype(`OPCODE_SW, 5'd0, 5'd5, 16'h0044), 32'h0000_013c);
      expect_issue(EN_LS);
      want.chk_ls_op   = 1'b1;
      want.ls_op       = `LS_FUNC_SW;
      want.chk_rtvalid = 1'b1;
      want.rtvalid     = 1'b1;
      finish_cycle(1'b0, 5'd0);
      // The store took no tag, so the next rename sees the same head.
      present(rtype(5'd0, 5'd0, 5'd11, 6'h20), 32'h0000_0140);
      expect_issue(EN_INT);
      finish_cycle(1'b1, 5'd11);

      // Random readies. Each instruction is held until its queue accepts it.
      for (int k = 0; k < 8; k++) begin
         dest = reg_addr_t'(12 + k);
         case (k % 4)
            0: begin
               inst  = rtype(5'd0, 5'd0, dest, 6'h20);
               queue = EN_INT;
            end
            1: begin
               inst  = rtype(5'd0, 5'd0, dest, `FUNCT_MULTU);
               queue = EN_MULT;
            end
            2: begin
               inst  = rtype(5'd0, 5'd0, dest, `FUNCT_DIVU);
               queue = EN_DIV;
            end
            default: begin
               inst  = itype(`OPCODE_LW, 5'd0, dest, 16'h0080);
               queue = EN_LS;
            end
         endcase
         dispatched = 1'b0;
         for (int n = 0; n < TIMEOUT && !dispatched; n++) begin
            rdy = 4'($urandom());
            {eq_div_ready, eq_mult_ready, eq_ls_ready, eq_int_ready} = rdy;
            present(inst, word_t'(32'h200 + 4 * k));
            expect_issue(rdy & queue);
            dispatched = |(rdy & queue);
            finish_cycle(dispatched, dest);
         end
         if (!dispatched) begin
            stop_with("An instruction was never accepted under random readies");
         end
      end
      {eq_div_ready, eq_mult_ready, eq_ls_ready, eq_int_ready} = 4'b1111;

      // A jump redirects fetch every cycle it is seen and is never popped.
      inst    = {`OPCODE_J, 26'h040_0100};
      jump_to = {4'h8, inst[25:0], 2'b00};
      for (int n = 0; n < 2; n++) begin
         present(inst, 32'h8000_0010);
         want.on    = 1'b1;
         want.bv    = 1'b1;
         want.baddr = jump_to;
         finish_cycle(1'b0, 5'd0);
      end
      ifq_empty = 1'b1;
      want.on   = 1'b1;
      finish_cycle(1'b0, 5'd0);

      // BEQ not taken. The next ADD waits for the outcome on the CDB.
      present(itype(`OPCODE_BEQ, 5'd0, 5'd0, 16'h0010), 32'h0000_0200);
      expect_issue(EN_INT);
      finish_cycle(1'b0, 5'd0);
      for (int n = 0; n < 4; n++) begin
         present(rtype(5'd0, 5'd0, 5'd20, 6'h20), 32'h0000_0204);
         want.on = 1'b1;
         finish_cycle(1'b0, 5'd0);
      end
      cdb.branch = 1'b1;
      expect_issue(EN_INT);
      finish_cycle(1'b1, 5'd20);

      // BNE taken with a backward offset.
      present(itype(`OPCODE_BNE, 5'd0, 5'd0, 16'hfff8), 32'h0000_0300);
      jump_to = branch_dest(32'h0000_0300, 16'hfff8);
      expect_issue(EN_INT);
      finish_cycle(1'b0, 5'd0);
      for (int n = 0; n < 3; n++) begin
         present(rtype(5'd0, 5'd0, 5'd21, 6'h20), 32'h0000_0304);
         want.on = 1'b1;
         finish_cycle(1'b0, 5'd0);
      end
      cdb.branch       = 1'b1;
      cdb.branch_taken = 1'b1;
      want.on          = 1'b1;
      want.bv          = 1'b1;
      want.baddr       = jump_to;
      finish_cycle(1'b0, 5'd0);
      ifq_empty = 1'b1;
      want.on   = 1'b1;
      finish_cycle(1'b0, 5'd0);

      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/tomasulo_pkg.sv
hdl/tag_fifo.sv
hdl/reg_status_table.sv
hdl/regfile.sv
hdl/dispatch_ctrl.sv
hdl/dispatch_top.sv
sim/tb_clock.sv
sim/dispatch_tb.sv

// ==== Makefile ====
SOURCES := verilog.f $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)

obj_dir/Vdispatch_tb: $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
		--top-module dispatch_tb -o Vdispatch_tb

.PHONY: run clean

run: obj_dir/Vdispatch_tb
	@out="$$(./obj_dir/Vdispatch_tb 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
